// ==== sim.f ====
rtl/isa_pkg.sv
rtl/cpu_pkg.sv
rtl/mips_decoder.sv
rtl/mips_execute.sv
rtl/mips_reg_file.sv
rtl/mips_mem_unit.sv
rtl/mips_fsm.sv
rtl/mips_cpu.sv
dv/tb_clock.sv
dv/tb_mips_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator; the exit status follows the result.
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_mips_cpu -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== dv/tb_mips_cpu.sv ====
`timescale 1ns/1ps

module tb_mips_cpu;

	import isa_pkg::*;
	import cpu_pkg::*;

	localparam word_t sentinel  = 32'h0000_0ffc;
	localparam int    alu_len   = 64; // Upper bounds of the program lengths.
	localparam int    byte_len  = 32;
	localparam int    flow_len  = 37;
	localparam int    slow_delay = 3;
	localparam int    total_insts = 2 * (alu_len + byte_len + flow_len);
	localparam int    timeout_cycles = total_insts * 10 * (slow_delay + 1) + 8 * 20;

	logic     clk;
	logic     rst;
	logic     restart;
	word_t    pc;
	logic     inst_req_valid;
	logic     inst_req_ack;
	inst_t    instruction;
	logic     inst_valid;
	logic     inst_ack;
	mem_req_t mem_req;
	logic     mem_req_ack;
	word_t    read_data;
	logic     read_data_valid;
	logic     read_data_ack;

	word_t imem [word_t];
	word_t dmem [word_t];
	inst_t prog [int];
	word_t exp_q [$];
	word_t fetch_log [$];
	word_t st_addr [$];
	word_t st_data [$];
	strb_t st_strb [$];
	logic  done;
	int    max_delay;
	int    errors;
	int    checks;
	word_t alu_a;
	word_t alu_b;
	imm_t  alu_imm;

	tb_clock u_clock (
		.restart (restart),
		.clk     (clk),
		.rst     (rst)
	);

	mips_cpu u_dut (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ack    (inst_req_ack),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ack        (inst_ack),
		.mem_req         (mem_req),
		.mem_req_ack     (mem_req_ack),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ack   (read_data_ack)
	);

	function automatic int pick_delay();
		return (max_delay == 0) ? 0 : $urandom_range(max_delay, 0);
	endfunction

	function automatic word_t read_word(word_t a, logic from_imem);
		if (from_imem)
			return imem.exists(a) ? imem[a] : '0; // Empty slots read as nop.
		return dmem.exists(a) ? dmem[a] : '0;
	endfunction

	function automatic inst_t enc_r(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			logic [4:0] sh);
		return {op_special, rs, rt, rd, sh, fn};
	endfunction

	function automatic inst_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic inst_t enc_j(opcode_t op, jidx_t idx);
		return {op, idx};
	endfunction

	task automatic emit(inst_t i);
		prog[prog.num()] = i;
	endtask

	// Sentinel store, then a branch to itself.
	task automatic end_program(int idx);
		prog[idx]     = enc_i(op_sw, 5'd0, 5'd0, sentinel[15:0]);
		prog[idx + 1] = enc_i(op_beq, 5'd0, 5'd0, 16'hffff);
	endtask

	task automatic fetch_model();
		word_t addr;
		forever begin
			@(negedge clk);
			if (!rst && inst_req_valid) begin
				repeat (pick_delay()) @(negedge clk);
				inst_req_ack = 1'b1;
				addr = pc;
				if (!rst)
					fetch_log.push_back(pc);
				@(negedge clk);
				inst_req_ack = 1'b0;
				repeat (pick_delay()) @(negedge clk);
				instruction = read_word(addr, 1'b1);
				inst_valid  = 1'b1;
				while (!rst && !inst_ack) // Held until the CPU takes it.
					@(negedge clk);
				@(negedge clk);
				inst_valid = 1'b0;
			end
		end
	endtask

	task automatic data_model();
		mem_req_t req;
		word_t    merged;
		forever begin
			@(negedge clk);
			if (!rst && (mem_req.write || mem_req.read)) begin
				repeat (pick_delay()) @(negedge clk);
				req = mem_req;
				mem_req_ack = 1'b1;
				@(negedge clk);
				mem_req_ack = 1'b0;
				if (req.write) begin
					merged = read_word(req.addr, 1'b0);
					for (int i = 0; i < 4; i++)
						if (req.wstrb[i])
							merged[8*i +: 8] = req.wdata[8*i +: 8];
					dmem[req.addr] = merged;
					st_addr.push_back(req.addr);
					st_data.push_back(req.wdata);
					st_strb.push_back(req.wstrb);
					if (req.addr == sentinel)
						done = 1'b1;
				end else begin
					repeat (pick_delay()) @(negedge clk);
					read_data       = read_word(req.addr, 1'b0);
					read_data_valid = 1'b1;
					while (!rst && !read_data_ack)
						@(negedge clk);
					@(negedge clk);
					read_data_valid = 1'b0;
				end
			end
		end
	endtask

	task automatic watchdog();
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: the CPU did not reach the end of the tests in time.");
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_strb(string name, strb_t got, strb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_mem(word_t addr, word_t exp);
		word_t got;
		got = read_word(addr, 1'b0);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR dmem[%h] got %h expected %h", addr, got, exp);
		end
	endtask

	task automatic check_store(int k, word_t addr, word_t data, strb_t strb);
		if (k >= st_addr.size()) begin
			errors++;
			$display("Store number %0d never reached the data memory.", k);
		end else begin
			check_word($sformatf("mem_req.addr[%0d]", k), st_addr[k], addr);
			check_word($sformatf("mem_req.wdata[%0d]", k), st_data[k], data);
			check_strb($sformatf("mem_req.wstrb[%0d]", k), st_strb[k], strb);
		end
	endtask

	// Loads the program under reset and runs it up to the sentinel store.
	task automatic run_program(int delay);
		restart = 1'b1;
		wait (rst);
		restart = 1'b0;
		repeat (6) @(negedge clk);
		imem.delete();
		foreach (prog[k])
			imem[word_t'(k) * word_bytes] = prog[k];
		fetch_log.delete();
		st_addr.delete();
		st_data.delete();
		st_strb.delete();
		done      = 1'b0;
		max_delay = delay;
		wait (!rst);
		while (!done)
			@(negedge clk);
	endtask

	task automatic test_reset();
		@(negedge clk);
		while (rst) begin
			if ({inst_req_valid, inst_ack, mem_req.write, mem_req.read,
					read_data_ack} !== 5'b0) begin
				errors++;
				$display("A handshake output of the CPU was high during reset.");
			end
			@(negedge clk);
		end
		while (fetch_log.size() == 0)
			@(negedge clk);
		check_word("first fetch pc", fetch_log[0], reset_pc);
	endtask

	task automatic alu_case(inst_t i, word_t exp);
		emit(i);
		emit(enc_i(op_sw, 5'd0, 5'd3, imm_t'(16'h0100 + 4 * exp_q.size())));
		exp_q.push_back(exp);
	endtask

	task automatic test_alu(int delay);
		word_t sx;
		word_t zx;
		sx = {{16{alu_imm[15]}}, alu_imm};
		zx = {16'h0, alu_imm};
		prog.delete();
		exp_q.delete();
		dmem.delete();
		emit(enc_i(op_lui, 5'd0, 5'd1, alu_a[31:16]));
		emit(enc_i(op_ori, 5'd1, 5'd1, alu_a[15:0]));
		emit(enc_i(op_lui, 5'd0, 5'd2, alu_b[31:16]));
		emit(enc_i(op_ori, 5'd2, 5'd2, alu_b[15:0]));
		alu_case(enc_r(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0), alu_a + alu_b);
		alu_case(enc_r(fn_subu, 5'd1, 5'd2, 5'd3, 5'd0), alu_a - alu_b);
		alu_case(enc_r(fn_and, 5'd1, 5'd2, 5'd3, 5'd0), alu_a & alu_b);
		alu_case(enc_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0), alu_a | alu_b);
		alu_case(enc_r(fn_xor, 5'd1, 5'd2, 5'd3, 5'd0), alu_a ^ alu_b);
		alu_case(enc_r(fn_nor, 5'd1, 5'd2, 5'd3, 5'd0), ~(alu_a | alu_b));
		alu_case(enc_r(fn_slt, 5'd1, 5'd2, 5'd3, 5'd0),
			word_t'($signed(alu_a) < $signed(alu_b)));
		alu_case(enc_r(fn_sltu, 5'd1, 5'd2, 5'd3, 5'd0), word_t'(alu_a < alu_b));
		alu_case(enc_r(fn_sllv, 5'd1, 5'd2, 5'd3, 5'd0), alu_b << alu_a[4:0]); // rt by rs.
		alu_case(enc_r(fn_srlv, 5'd1, 5'd2, 5'd3, 5'd0), alu_b >> alu_a[4:0]);
		alu_case(enc_r(fn_srav, 5'd1, 5'd2, 5'd3, 5'd0),
			word_t'($signed(alu_b) >>> alu_a[4:0]));
		alu_case(enc_r(fn_sll, 5'd0, 5'd2, 5'd3, 5'd7), alu_b << 7);
		alu_case(enc_r(fn_srl, 5'd0, 5'd2, 5'd3, 5'd7), alu_b >> 7);
		alu_case(enc_r(fn_sra, 5'd0, 5'd2, 5'd3, 5'd7), word_t'($signed(alu_b) >>> 7));
		alu_case(enc_i(op_addiu, 5'd1, 5'd3, alu_imm), alu_a + sx);
		alu_case(enc_i(op_slti, 5'd1, 5'd3, alu_imm), word_t'($signed(alu_a) < $signed(sx)));
		alu_case(enc_i(op_sltiu, 5'd1, 5'd3, alu_imm), word_t'(alu_a < sx));
		alu_case(enc_i(op_andi, 5'd1, 5'd3, alu_imm), alu_a & zx);
		alu_case(enc_i(op_ori, 5'd1, 5'd3, alu_imm), alu_a | zx);
		alu_case(enc_i(op_xori, 5'd1, 5'd3, alu_imm), alu_a ^ zx);
		alu_case(enc_i(op_lui, 5'd0, 5'd3, alu_imm), {alu_imm, 16'h0});
		end_program(prog.num());
		run_program(delay);
		foreach (exp_q[k])
			check_store(k, 32'h100 + 4 * k, exp_q[k], 4'hf);
	endtask

	task automatic test_bytes(int delay);
		word_t loaded [5];
		loaded = '{32'hffff_ff80, 32'h0000_0080, 32'h0000_007f, 32'h0000_007f, 32'h007f_8000};
		prog.delete();
		dmem.delete();
		dmem[32'h300] = 32'h007f_8000; // 8'h80 at byte 1, 8'h7f at byte 2.
		emit(enc_i(op_ori, 5'd0, 5'd4, 16'h00c3));
		for (int k = 0; k < 4; k++)
			emit(enc_i(op_sb, 5'd0, 5'd4, imm_t'(16'h0200 + k)));
		emit(enc_i(op_lb, 5'd0, 5'd5, 16'h0301));
		emit(enc_i(op_lbu, 5'd0, 5'd6, 16'h0301));
		emit(enc_i(op_lb, 5'd0, 5'd7, 16'h0302));
		emit(enc_i(op_lbu, 5'd0, 5'd8, 16'h0302));
		emit(enc_i(op_lw, 5'd0, 5'd9, 16'h0300));
		for (int j = 0; j < 5; j++)
			emit(enc_i(op_sw, 5'd0, reg_addr_t'(5 + j), imm_t'(16'h0400 + 4 * j)));
		end_program(prog.num());
		run_program(delay);
		for (int k = 0; k < 4; k++)
			check_store(k, 32'h200, 32'hc3c3_c3c3, strb_t'(4'b0001 << k));
		for (int j = 0; j < 5; j++)
			check_store(4 + j, 32'h400 + 4 * j, loaded[j], 4'hf);
		check_mem(32'h200, 32'hc3c3_c3c3);
	endtask

	task automatic test_flow(int delay);
		int walk [23];
		walk = '{0, 1, 2, 4, 5, 7, 8, 10, 11, 13, 14, 16, 17, 19, 20, 22, 26, 24, 25, 29,
			30, 34, 35};
		prog.delete();
		dmem.delete();
		prog[0]  = enc_i(op_addiu, 5'd0, 5'd1, 16'd5);
		prog[1]  = enc_i(op_addiu, 5'd0, 5'd2, 16'hfffd);
		prog[2]  = enc_i(op_beq, 5'd1, 5'd1, 16'd1); // Taken.
		prog[4]  = enc_i(op_beq, 5'd1, 5'd2, 16'd1);
		prog[5]  = enc_i(op_bne, 5'd1, 5'd2, 16'd1); // Taken.
		prog[7]  = enc_i(op_bne, 5'd1, 5'd1, 16'd1);
		prog[8]  = enc_i(op_regimm, 5'd1, rt_bgez, 16'd1); // Taken.
		prog[10] = enc_i(op_regimm, 5'd2, rt_bgez, 16'd1);
		prog[11] = enc_i(op_bgtz, 5'd1, 5'd0, 16'd1); // Taken.
		prog[13] = enc_i(op_bgtz, 5'd0, 5'd0, 16'd1);
		prog[14] = enc_i(op_blez, 5'd2, 5'd0, 16'd1); // Taken.
		prog[16] = enc_i(op_blez, 5'd1, 5'd0, 16'd1);
		prog[17] = enc_i(op_regimm, 5'd2, rt_bltz, 16'd1); // Taken.
		prog[19] = enc_i(op_regimm, 5'd0, rt_bltz, 16'd1);
		prog[20] = enc_j(op_j, 26'd22);
		prog[22] = enc_j(op_jal, 26'd26); // Link is 96, so the return lands on slot 24.
		prog[24] = enc_i(op_sw, 5'd0, ra_reg, 16'h0500);
		prog[25] = enc_j(op_j, 26'd29);
		prog[26] = enc_r(fn_jr, ra_reg, 5'd0, 5'd0, 5'd0);
		prog[29] = enc_i(op_addiu, 5'd0, 5'd11, 16'd136); // Target slot 34, link 128.
		prog[30] = enc_r(fn_jalr, 5'd11, 5'd0, ra_reg, 5'd0);
		prog[34] = enc_i(op_sw, 5'd0, ra_reg, 16'h0504);
		end_program(35);
		run_program(delay);
		if (fetch_log.size() < $size(walk)) begin
			errors++;
			$display("Only %0d fetches seen, %0d expected.", fetch_log.size(), $size(walk));
		end else begin
			foreach (walk[k])
				check_word($sformatf("pc[%0d]", k), fetch_log[k], word_t'(walk[k]) * 4);
		end
		check_store(0, 32'h500, 32'd96, 4'hf);
		check_store(1, 32'h504, 32'd128, 4'hf);
	endtask

	initial begin
		restart         = 1'b0;
		inst_req_ack    = 1'b0;
		instruction     = '0;
		inst_valid      = 1'b0;
		mem_req_ack     = 1'b0;
		read_data       = '0;
		read_data_valid = 1'b0;
		done            = 1'b0;
		max_delay       = 0;
		errors          = 0;
		checks          = 0;
		void'($urandom(32'hebdc_d267));
		alu_a   = $urandom;
		alu_b   = $urandom;
		alu_imm = imm_t'($urandom);
		fork
			fetch_model();
			data_model();
			watchdog();
		join_none
		test_reset();
		test_alu(0);
		test_bytes(0);
		test_flow(0);
		test_alu(slow_delay); // Same programs under back-pressure.
		test_bytes(slow_delay);
		test_flow(slow_delay);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period.

	// Reset lasts eight cycles at start and on each restart request.
	initial begin
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		forever begin
			@(negedge clk);
			if (restart) begin
				rst = 1'b1;
				repeat (8) @(negedge clk);
				rst = 1'b0;
			end
		end
	end

endmodule

// ==== rtl/mips_cpu.sv ====
`timescale 1ns/1ps

module mips_cpu (
	input  logic              clk,
	input  logic              rst,
	output isa_pkg::word_t    pc,
	output logic              inst_req_valid,
	input  logic              inst_req_ack,
	input  isa_pkg::inst_t    instruction,
	input  logic              inst_valid,
	output logic              inst_ack,
	output cpu_pkg::mem_req_t mem_req,
	input  logic              mem_req_ack,
	input  isa_pkg::word_t    read_data,
	input  logic              read_data_valid,
	output logic              read_data_ack
);

	import isa_pkg::*;
	import cpu_pkg::*;

	ctrl_t ctrl;
	inst_t inst;
	word_t rs_value;
	word_t rt_value;
	word_t alu_result;
	word_t br_target;
	word_t wb_data;
	logic  br_taken;
	logic  rf_wen;
	logic  mem_write_en;
	logic  mem_read_en;

	mips_fsm u_fsm (
		.clk             (clk),
		.rst             (rst),
		.ctrl            (ctrl),
		.br_taken        (br_taken),
		.br_target       (br_target),
		.inst_req_ack    (inst_req_ack),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.mem_req_ack     (mem_req_ack),
		.read_data_valid (read_data_valid),
		.pc              (pc),
		.inst            (inst),
		.inst_req_valid  (inst_req_valid),
		.inst_ack        (inst_ack),
		.mem_write_en    (mem_write_en),
		.mem_read_en     (mem_read_en),
		.read_data_ack   (read_data_ack),
		.rf_wen          (rf_wen)
	);

	mips_decoder u_decoder (
		.inst (inst),
		.ctrl (ctrl)
	);

	mips_reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (inst[25:21]), // rs
		.raddr2 (inst[20:16]), // rt
		.waddr  (ctrl.dest),
		.wen    (rf_wen),
		.wdata  (wb_data),
		.rdata1 (rs_value),
		.rdata2 (rt_value)
	);

	mips_execute u_execute (
		.ctrl       (ctrl),
		.inst       (inst),
		.pc         (pc),
		.rs_value   (rs_value),
		.rt_value   (rt_value),
		.alu_result (alu_result),
		.br_target  (br_target),
		.br_taken   (br_taken)
	);

	mips_mem_unit u_mem_unit (
		.clk             (clk),
		.rst             (rst),
		.ctrl            (ctrl),
		.alu_result      (alu_result),
		.rt_value        (rt_value),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ack   (read_data_ack),
		.mem_write_en    (mem_write_en),
		.mem_read_en     (mem_read_en),
		.mem_req         (mem_req),
		.wb_data         (wb_data)
	);

endmodule

// ==== rtl/mips_fsm.sv ====
`timescale 1ns/1ps

module mips_fsm (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::ctrl_t ctrl,
	input  logic           br_taken,
	input  isa_pkg::word_t br_target,
	input  logic           inst_req_ack,
	input  isa_pkg::inst_t instruction,
	input  logic           inst_valid,
	input  logic           mem_req_ack,
	input  logic           read_data_valid,
	output isa_pkg::word_t pc,
	output isa_pkg::inst_t inst,
	output logic           inst_req_valid,
	output logic           inst_ack,
	output logic           mem_write_en,
	output logic           mem_read_en,
	output logic           read_data_ack,
	output logic           rf_wen
);

	import isa_pkg::*;
	import cpu_pkg::*;

	state_e state;
	state_e state_next;
	word_t  next_pc;

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_init;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			st_init: state_next = st_fetch_req;
			st_fetch_req:
				if (inst_req_valid && inst_req_ack)
					state_next = st_fetch_wait;
			st_fetch_wait:
				if (inst_ack && inst_valid)
					state_next = st_decode;
			st_decode: state_next = st_exec;
			st_exec: begin
				if (ctrl.br != br_none && !ctrl.link)
					state_next = st_fetch_req;
				else if (ctrl.is_store)
					state_next = st_store;
				else if (ctrl.is_load)
					state_next = st_load_req;
				else
					state_next = st_wb; // Links write back here too.
			end
			st_store:
				if (mem_write_en && mem_req_ack)
					state_next = st_fetch_req;
			st_load_req:
				if (mem_read_en && mem_req_ack)
					state_next = st_read_wait;
			st_read_wait:
				if (read_data_ack && read_data_valid)
					state_next = st_wb;
			st_wb: state_next = st_fetch_req;
			default: state_next = st_init;
		endcase
	end

	// Resolved in decode while rs and rt are settled.
	always_ff @(posedge clk) begin
		if (rst)
			next_pc <= reset_pc;
		else if (state == st_decode)
			next_pc <= br_taken ? br_target : pc + word_bytes;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= reset_pc;
		else if (state != st_fetch_req && state_next == st_fetch_req)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		if (inst_ack && inst_valid)
			inst <= instruction;
	end

	assign inst_req_valid = state == st_fetch_req;
	assign inst_ack       = state == st_fetch_wait;
	assign mem_write_en   = state == st_store && ctrl.is_store;
	assign mem_read_en    = state == st_load_req && ctrl.is_load;
	assign read_data_ack  = state == st_read_wait;
	assign rf_wen         = state == st_wb && ctrl.reg_write;

endmodule

// ==== rtl/mips_mem_unit.sv ====
`timescale 1ns/1ps

module mips_mem_unit (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::ctrl_t    ctrl,
	input  isa_pkg::word_t    alu_result,
	input  isa_pkg::word_t    rt_value,
	input  isa_pkg::word_t    read_data,
	input  logic              read_data_valid,
	input  logic              read_data_ack,
	input  logic              mem_write_en,
	input  logic              mem_read_en,
	output cpu_pkg::mem_req_t mem_req,
	output isa_pkg::word_t    wb_data
);

	import isa_pkg::*;

	logic [1:0] byte_sel;
	strb_t      strb;
	word_t      read_data_q;
	logic [7:0] load_byte;
	word_t      load_ext;

	assign byte_sel = alu_result[1:0];
	assign strb     = ctrl.byte_access ? strb_t'(4'b0001 << byte_sel) : 4'b1111;

	always_comb begin
		mem_req.addr  = {alu_result[31:2], 2'b00};
		mem_req.wdata = ctrl.byte_access ? {4{rt_value[7:0]}} : rt_value; // Byte on every lane.
		mem_req.wstrb = strb;
		mem_req.write = mem_write_en;
		mem_req.read  = mem_read_en;
	end

	always_ff @(posedge clk) begin
		if (rst)
			read_data_q <= '0;
		else if (read_data_valid && read_data_ack)
			read_data_q <= read_data;
	end

	assign load_byte = read_data_q[{byte_sel, 3'b000} +: 8];
	assign load_ext  = ctrl.load_unsigned ? {24'b0, load_byte} : {{24{load_byte[7]}}, load_byte};

	always_comb begin
		if (!ctrl.is_load)
			wb_data = alu_result; // Also carries the link value.
		else if (ctrl.byte_access)
			wb_data = load_ext;
		else
			wb_data = read_data_q;
	end

endmodule

// ==== rtl/mips_reg_file.sv ====
`timescale 1ns/1ps

module mips_reg_file (
	input  logic               clk,
	input  logic               rst,
	input  isa_pkg::reg_addr_t raddr1,
	input  isa_pkg::reg_addr_t raddr2,
	input  isa_pkg::reg_addr_t waddr,
	input  logic               wen,
	input  isa_pkg::word_t     wdata,
	output isa_pkg::word_t     rdata1,
	output isa_pkg::word_t     rdata2
);

	import isa_pkg::*;

	word_t regs [2**$bits(reg_addr_t)];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**$bits(reg_addr_t); i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/mips_execute.sv ====
`timescale 1ns/1ps

module mips_execute (
	input  cpu_pkg::ctrl_t ctrl,
	input  isa_pkg::inst_t inst,
	input  isa_pkg::word_t pc,
	input  isa_pkg::word_t rs_value,
	input  isa_pkg::word_t rt_value,
	output isa_pkg::word_t alu_result,
	output isa_pkg::word_t br_target,
	output logic           br_taken
);

	import isa_pkg::*;
	import cpu_pkg::*;

	imm_t  imm;
	jidx_t jidx;
	word_t imm_sext;
	word_t src1;
	word_t src2;
	logic  rs_zero;
	logic  rs_neg;

	assign imm      = inst[15:0];
	assign jidx     = inst[25:0];
	assign imm_sext = {{16{imm[15]}}, imm};

	always_comb begin
		case (ctrl.src1)
			src1_shamt: src1 = {27'b0, inst[10:6]};
			src1_pc:    src1 = pc;
			default:    src1 = rs_value;
		endcase
		case (ctrl.src2)
			src2_simm:  src2 = imm_sext;
			src2_zimm:  src2 = {16'b0, imm};
			src2_eight: src2 = link_offset; // Link value is pc + 8.
			default:    src2 = rt_value;
		endcase
	end

	always_comb begin
		case (ctrl.alu_op)
			alu_sub:  alu_result = src1 - src2;
			alu_and:  alu_result = src1 & src2;
			alu_or:   alu_result = src1 | src2;
			alu_xor:  alu_result = src1 ^ src2;
			alu_nor:  alu_result = ~(src1 | src2);
			alu_slt:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
			alu_sltu: alu_result = {31'b0, src1 < src2};
			alu_sll:  alu_result = src2 << src1[4:0]; // Shift amount in src1.
			alu_srl:  alu_result = src2 >> src1[4:0];
			alu_sra:  alu_result = word_t'($signed(src2) >>> src1[4:0]);
			alu_lui:  alu_result = {src2[15:0], 16'b0};
			default:  alu_result = src1 + src2;
		endcase
	end

	assign rs_zero = rs_value == '0;
	assign rs_neg  = rs_value[31];

	always_comb begin
		case (ctrl.br)
			br_eq:       br_taken = rs_value == rt_value;
			br_ne:       br_taken = rs_value != rt_value;
			br_gez:      br_taken = !rs_neg;
			br_gtz:      br_taken = !rs_neg && !rs_zero;
			br_lez:      br_taken = rs_neg || rs_zero;
			br_ltz:      br_taken = rs_neg;
			br_jump:     br_taken = 1'b1;
			br_jump_reg: br_taken = 1'b1;
			default:     br_taken = 1'b0;
		endcase
	end

	// No delay slot, so branch offsets count from pc + 4.
	always_comb begin
		case (ctrl.br)
			br_jump:     br_target = {pc[31:28], jidx, 2'b00};
			br_jump_reg: br_target = rs_value;
			default:     br_target = pc + word_bytes + (imm_sext << 2);
		endcase
	end

endmodule

// ==== rtl/mips_decoder.sv ====
`timescale 1ns/1ps

module mips_decoder (
	input  isa_pkg::inst_t inst,
	output cpu_pkg::ctrl_t ctrl
);

	import isa_pkg::*;
	import cpu_pkg::*;

	opcode_t   opcode;
	reg_addr_t rt;
	reg_addr_t rd;
	funct_t    funct;

	assign opcode = inst[31:26];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign funct  = inst[5:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			op_special: begin
				ctrl.dest      = rd;
				ctrl.reg_write = 1'b1;
				case (funct)
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_xor:  ctrl.alu_op = alu_xor;
					fn_nor:  ctrl.alu_op = alu_nor;
					fn_slt:  ctrl.alu_op = alu_slt;
					fn_sltu: ctrl.alu_op = alu_sltu;
					fn_sllv: ctrl.alu_op = alu_sll; // Amount from rs.
					fn_srlv: ctrl.alu_op = alu_srl;
					fn_srav: ctrl.alu_op = alu_sra;
					fn_sll: begin
						ctrl.alu_op = alu_sll;
						ctrl.src1   = src1_shamt;
					end
					fn_srl: begin
						ctrl.alu_op = alu_srl;
						ctrl.src1   = src1_shamt;
					end
					fn_sra: begin
						ctrl.alu_op = alu_sra;
						ctrl.src1   = src1_shamt;
					end
					fn_jr: begin
						ctrl.br        = br_jump_reg;
						ctrl.reg_write = 1'b0;
					end
					fn_jalr: begin
						ctrl.br   = br_jump_reg;
						ctrl.link = 1'b1;
						ctrl.src1 = src1_pc;
						ctrl.src2 = src2_eight;
						ctrl.dest = ra_reg;
					end
					default: ctrl = '0;
				endcase
			end
			op_regimm: begin
				if (rt == rt_bgez)
					ctrl.br = br_gez;
				else if (rt == rt_bltz)
					ctrl.br = br_ltz;
			end
			op_beq:  ctrl.br = br_eq;
			op_bne:  ctrl.br = br_ne;
			op_blez: ctrl.br = br_lez;
			op_bgtz: ctrl.br = br_gtz;
			op_j:    ctrl.br = br_jump;
			op_jal: begin
				ctrl.br        = br_jump;
				ctrl.link      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.src1      = src1_pc;
				ctrl.src2      = src2_eight;
				ctrl.dest      = ra_reg;
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
				ctrl.dest      = rt;
				ctrl.reg_write = 1'b1;
				ctrl.src2      = src2_simm;
				if (opcode == op_slti)
					ctrl.alu_op = alu_slt;
				else if (opcode == op_sltiu)
					ctrl.alu_op = alu_sltu; // Sign-extended, compared unsigned.
				else if (opcode != op_addiu) begin
					ctrl.src2 = src2_zimm;
					if (opcode == op_andi)
						ctrl.alu_op = alu_and;
					else if (opcode == op_ori)
						ctrl.alu_op = alu_or;
					else if (opcode == op_xori)
						ctrl.alu_op = alu_xor;
					else
						ctrl.alu_op = alu_lui;
				end
			end
			op_lw, op_lb, op_lbu: begin
				ctrl.src2          = src2_simm;
				ctrl.dest          = rt;
				ctrl.reg_write     = 1'b1;
				ctrl.is_load       = 1'b1;
				ctrl.byte_access   = opcode != op_lw;
				ctrl.load_unsigned = opcode == op_lbu;
			end
			op_sw, op_sb: begin
				ctrl.src2        = src2_simm;
				ctrl.is_store    = 1'b1;
				ctrl.byte_access = opcode == op_sb;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	typedef enum logic [3:0] {
		st_init,
		st_fetch_req,
		st_fetch_wait,
		st_decode,
		st_exec,
		st_store,
		st_load_req,
		st_read_wait,
		st_wb
	} state_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {src1_rs, src1_shamt, src1_pc} src1_e;

	typedef enum logic [1:0] {src2_rt, src2_simm, src2_zimm, src2_eight} src2_e;

	typedef enum logic [3:0] {
		br_none,
		br_eq,
		br_ne,
		br_gez,
		br_gtz,
		br_lez,
		br_ltz,
		br_jump,
		br_jump_reg
	} br_e;

	// All zero decodes to an instruction with no effect.
	typedef struct packed {
		alu_op_e           alu_op;
		src1_e             src1;
		src2_e             src2;
		br_e               br;
		isa_pkg::reg_addr_t dest;
		logic              reg_write;
		logic              link;
		logic              is_load;
		logic              is_store;
		logic              byte_access;
		logic              load_unsigned;
	} ctrl_t;

	typedef struct packed {
		isa_pkg::word_t addr;
		isa_pkg::word_t wdata;
		isa_pkg::strb_t wstrb;
		logic           write;
		logic           read;
	} mem_req_t;

	localparam isa_pkg::word_t link_offset = 32'd8;
	localparam isa_pkg::word_t reset_pc    = 32'h0000_0000;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [15:0] imm_t;
	typedef logic [25:0] jidx_t;
	typedef logic [3:0]  strb_t;

	// Primary opcodes.
	localparam opcode_t op_special = 6'b000000;
	localparam opcode_t op_regimm  = 6'b000001;
	localparam opcode_t op_j       = 6'b000010;
	localparam opcode_t op_jal     = 6'b000011;
	localparam opcode_t op_beq     = 6'b000100;
	localparam opcode_t op_bne     = 6'b000101;
	localparam opcode_t op_blez    = 6'b000110;
	localparam opcode_t op_bgtz    = 6'b000111;
	localparam opcode_t op_addiu   = 6'b001001;
	localparam opcode_t op_slti    = 6'b001010;
	localparam opcode_t op_sltiu   = 6'b001011;
	localparam opcode_t op_andi    = 6'b001100;
	localparam opcode_t op_ori     = 6'b001101;
	localparam opcode_t op_xori    = 6'b001110;
	localparam opcode_t op_lui     = 6'b001111;
	localparam opcode_t op_lb      = 6'b100000;
	localparam opcode_t op_lw      = 6'b100011;
	localparam opcode_t op_lbu     = 6'b100100;
	localparam opcode_t op_sb      = 6'b101000;
	localparam opcode_t op_sw      = 6'b101011;

	// Function codes under op_special.
	localparam funct_t fn_sll  = 6'b000000;
	localparam funct_t fn_srl  = 6'b000010;
	localparam funct_t fn_sra  = 6'b000011;
	localparam funct_t fn_sllv = 6'b000100;
	localparam funct_t fn_srlv = 6'b000110;
	localparam funct_t fn_srav = 6'b000111;
	localparam funct_t fn_jr   = 6'b001000;
	localparam funct_t fn_jalr = 6'b001001;
	localparam funct_t fn_addu = 6'b100001;
	localparam funct_t fn_subu = 6'b100011;
	localparam funct_t fn_and  = 6'b100100;
	localparam funct_t fn_or   = 6'b100101;
	localparam funct_t fn_xor  = 6'b100110;
	localparam funct_t fn_nor  = 6'b100111;
	localparam funct_t fn_slt  = 6'b101010;
	localparam funct_t fn_sltu = 6'b101011;

	localparam reg_addr_t rt_bltz = 5'b00000; // Selectors under op_regimm.
	localparam reg_addr_t rt_bgez = 5'b00001;

	localparam reg_addr_t ra_reg     = 5'd31;
	localparam word_t     word_bytes = 32'd4;

endpackage
